/* compile.f */
+incdir+include
design/core_pkg.sv
design/core_op_if.sv
design/core_sequencer.sv
design/soft_reset_timer.sv
design/core_decode.sv
design/core_exec.sv
design/core_regfile.sv
design/tiny_rv_core.sv
verif/core_assertions.sv
verif/core_tb.sv

/* design/core_decode.sv */
/*
 * Decode stage. Holds the fetched instruction, classifies it, builds its
 * immediate and presents the operands read from the register file.
 * Outputs stay valid from ST_DECODE until the next fetch completes.
 */
`timescale 1ns/1ps

module core_decode (
	input logic clock,
	input logic reset,
	input logic fetch_done,
	input core_pkg::word_t idata,
	input core_pkg::word_t pc,
	output core_pkg::reg_addr_t rs1,
	output core_pkg::reg_addr_t rs2,
	input core_pkg::word_t rs1_val,
	input core_pkg::word_t rs2_val,
	core_op_if.decode op
);

	core_pkg::word_t ir;
	core_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	core_pkg::op_kind_t kind;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic writes_rd;

	always_ff @(posedge clock) begin
		if (reset) begin
			ir <= '0;    // Decodes as OP_NOP
		end else if (fetch_done) begin
			ir <= idata;
		end
	end

	assign opcode = ir[6:0];
	assign funct3 = ir[14:12];
	assign funct7 = ir[31:25];
	assign rs1 = ir[19:15];
	assign rs2 = ir[24:20];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u = {ir[31:12], 12'b0};
	assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

	always_comb begin
		kind = core_pkg::OP_NOP;
		case (opcode)
			7'b0110111: kind = core_pkg::OP_LUI;
			7'b0010011: if (funct3 == 3'b000) kind = core_pkg::OP_ADDI;
			7'b0110011: begin
				case ({funct7, funct3})
					10'b0000000_000: kind = core_pkg::OP_ADD;
					10'b0100000_000: kind = core_pkg::OP_SUB;
					10'b0000000_111: kind = core_pkg::OP_AND;
					10'b0000000_110: kind = core_pkg::OP_OR;
					10'b0000000_100: kind = core_pkg::OP_XOR;
					10'b0000000_010: kind = core_pkg::OP_SLT;
					default: kind = core_pkg::OP_NOP;
				endcase
			end
			7'b0000011: if (funct3 == 3'b010) kind = core_pkg::OP_LW;
			7'b0100011: if (funct3 == 3'b010) kind = core_pkg::OP_SW;
			7'b1100011: begin
				if (funct3 == 3'b000) kind = core_pkg::OP_BEQ;
				else if (funct3 == 3'b001) kind = core_pkg::OP_BNE;
			end
			7'b1101111: kind = core_pkg::OP_JAL;
			default: kind = core_pkg::OP_NOP;
		endcase
	end

	always_comb begin
		case (kind)
			core_pkg::OP_LUI: op.imm = imm_u;
			core_pkg::OP_SW: op.imm = imm_s;
			core_pkg::OP_BEQ, core_pkg::OP_BNE: op.imm = imm_b;
			core_pkg::OP_JAL: op.imm = imm_j;
			default: op.imm = imm_i;    // ADDI, LW, unused elsewhere
		endcase
	end

	// Stores, branches and no-ops have no destination
	assign writes_rd = !(kind inside {core_pkg::OP_SW, core_pkg::OP_BEQ,
		core_pkg::OP_BNE, core_pkg::OP_NOP});

	assign op.kind = kind;
	assign op.rd = writes_rd ? ir[11:7] : '0;
	assign op.a_val = rs1_val;
	assign op.b_val = rs2_val;
	assign op.pc = pc;

endmodule

/* design/core_exec.sv */
/*
 * Execute and writeback. Computes the ALU result, branch outcome and
 * memory request in ST_EXEC, takes load data on the data transfer, and
 * commits the register write and the next PC in ST_WB.
 * The pc output doubles as the fetch address.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_exec (
	input logic clock,
	input logic reset,
	input logic exec_en,
	input logic wb_en,
	input logic mem_done,
	core_op_if.exec op,
	input core_pkg::word_t drdata,
	output core_pkg::word_t pc,
	output core_pkg::word_t daddr,
	output core_pkg::word_t dwdata,
	output logic dwrite,
	output logic [3:0] dwstb,
	output core_pkg::reg_addr_t rd_waddr,
	output core_pkg::word_t rd_wdata,
	output logic rd_wen,
	output logic soft_reset_req
);

	core_pkg::word_t alu_result;
	core_pkg::word_t result_q;
	core_pkg::word_t next_pc_q;
	logic taken;

	always_comb begin
		alu_result = '0;
		taken = 1'b0;
		case (op.kind)
			core_pkg::OP_LUI: alu_result = op.imm;
			core_pkg::OP_ADDI: alu_result = op.a_val + op.imm;
			core_pkg::OP_ADD: alu_result = op.a_val + op.b_val;
			core_pkg::OP_SUB: alu_result = op.a_val - op.b_val;
			core_pkg::OP_AND: alu_result = op.a_val & op.b_val;
			core_pkg::OP_OR: alu_result = op.a_val | op.b_val;
			core_pkg::OP_XOR: alu_result = op.a_val ^ op.b_val;
			core_pkg::OP_SLT: alu_result = core_pkg::word_t'($signed(op.a_val) < $signed(op.b_val));
			core_pkg::OP_BEQ: taken = (op.a_val == op.b_val);
			core_pkg::OP_BNE: taken = (op.a_val != op.b_val);
			core_pkg::OP_JAL: begin
				alu_result = op.pc + 32'd4;    // Link address
				taken = 1'b1;
			end
			default: alu_result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= `CORE_RESET_PC;
			dwrite <= 1'b0;
		end else begin
			if (exec_en) begin
				dwrite <= (op.kind == core_pkg::OP_SW);
			end
			if (wb_en) begin
				pc <= next_pc_q;
				dwrite <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (exec_en) begin
			result_q <= alu_result;
			next_pc_q <= taken ? op.pc + op.imm : op.pc + 32'd4;
			daddr <= op.a_val + op.imm;    // Held stable through ST_MEM
			dwdata <= op.b_val;
		end
		if (mem_done && !dwrite) begin
			result_q <= drdata;    // Load data
		end
	end

	assign dwstb = dwrite ? 4'hF : 4'h0;
	assign soft_reset_req = mem_done && dwrite && (daddr == `CORE_SOFT_RESET_ADDR);

	assign rd_waddr = op.rd;
	assign rd_wdata = result_q;
	assign rd_wen = wb_en && (op.rd != '0);

endmodule

/* design/core_op_if.sv */
/*
 * One decoded instruction, as produced by decode.
 * Execute consumes all of it; the sequencer only looks at the kind.
 */
`timescale 1ns/1ps

interface core_op_if;

	core_pkg::op_kind_t kind;
	core_pkg::reg_addr_t rd;    // Zero when nothing is written back
	core_pkg::word_t a_val;
	core_pkg::word_t b_val;
	core_pkg::word_t imm;
	core_pkg::word_t pc;

	modport decode (output kind, rd, a_val, b_val, imm, pc);
	modport exec (input kind, rd, a_val, b_val, imm, pc);
	modport seq (input kind);

endinterface

/* design/core_pkg.sv */
/*
 * Shared types of the tiny RISC-V core: data and register index vectors,
 * the decoded instruction kinds and the sequencer states.
 * Referenced by scoped names from the RTL and the testbench.
 */
`include "core_defs.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0] word_t;
	typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		OP_LUI, OP_ADDI, OP_ADD, OP_SUB,
		OP_AND, OP_OR, OP_XOR, OP_SLT,
		OP_LW, OP_SW, OP_BEQ, OP_BNE,
		OP_JAL, OP_NOP
	} op_kind_t;

	typedef enum logic [2:0] {
		ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB
	} seq_state_t;

endpackage

/* design/core_regfile.sv */
/*
 * Integer register file with two combinational read ports and one
 * write port. x0 is not stored and always reads zero.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_regfile (
	input logic clock,
	input logic reset,
	input logic rd_wen,
	input core_pkg::reg_addr_t rs1,
	input core_pkg::reg_addr_t rs2,
	input core_pkg::reg_addr_t rd_waddr,
	input core_pkg::word_t rd_wdata,
	output core_pkg::word_t rs1_val,
	output core_pkg::word_t rs2_val
);

	core_pkg::word_t regs [1:`CORE_NREGS-1];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;    // Soft reset must leave all zeros
			end
		end else if (rd_wen && (rd_waddr != '0)) begin
			regs[rd_waddr] <= rd_wdata;
		end
	end

	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/core_sequencer.sv */
/*
 * Multicycle control FSM. Steps each instruction through fetch, decode,
 * execute, an optional memory access and writeback, and issues the
 * valid strobes of both memory ports.
 */
`timescale 1ns/1ps

module core_sequencer (
	input logic clock,
	input logic reset,
	core_op_if.seq op,
	input logic iready,
	input logic dready,
	output logic ivalid,
	output logic dvalid,
	output logic exec_en,
	output logic wb_en
);

	core_pkg::seq_state_t state;
	logic mem_op;    // Current instruction needs ST_MEM

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= core_pkg::ST_FETCH;
			mem_op <= 1'b0;
		end else begin
			case (state)
				core_pkg::ST_FETCH: begin
					if (ivalid && iready) begin
						state <= core_pkg::ST_DECODE;
					end
				end
				core_pkg::ST_DECODE: begin
					mem_op <= (op.kind == core_pkg::OP_LW) || (op.kind == core_pkg::OP_SW);
					state <= core_pkg::ST_EXEC;
				end
				core_pkg::ST_EXEC: state <= mem_op ? core_pkg::ST_MEM : core_pkg::ST_WB;
				core_pkg::ST_MEM: begin
					if (dready) begin    // dvalid is high throughout ST_MEM
						state <= core_pkg::ST_WB;
					end
				end
				default: state <= core_pkg::ST_FETCH;    // ST_WB
			endcase
		end
	end

	// Fetch request must not show while reset is held
	assign ivalid = (state == core_pkg::ST_FETCH) && !reset;
	assign dvalid = (state == core_pkg::ST_MEM);
	assign exec_en = (state == core_pkg::ST_EXEC);
	assign wb_en = (state == core_pkg::ST_WB);

endmodule

/* design/soft_reset_timer.sv */
/*
 * Internal reset generator. A software request holds the rest of the
 * core in reset for a fixed number of cycles; the external reset
 * passes straight through.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module soft_reset_timer (
	input logic clock,
	input logic reset,
	input logic soft_reset_req,
	output logic int_reset
);

	logic [4:0] count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (soft_reset_req) begin
			count <= 5'(`CORE_SOFT_RESET_CYCLES);
		end else if (count != '0) begin
			count <= count - 5'd1;
		end
	end

	assign int_reset = reset || (count != '0);

endmodule

/* design/tiny_rv_core.sv */
/*
 * Top level of the tiny multicycle RISC-V core. Connects the stage
 * blocks to plain instruction and data memory ports, each with a
 * valid/ready handshake, and drives the internal reset that a
 * software store to the soft reset address stretches.
 */
`timescale 1ns/1ps

module tiny_rv_core (
	input logic clock,
	input logic reset,
	output core_pkg::word_t iaddr,
	input core_pkg::word_t idata,
	output logic ivalid,
	input logic iready,
	output logic dvalid,
	output core_pkg::word_t daddr,
	output core_pkg::word_t dwdata,
	output logic [3:0] dwstb,
	output logic dwrite,
	input core_pkg::word_t drdata,
	input logic dready
);

	logic int_reset;
	logic soft_reset_req;
	logic fetch_done;
	logic mem_done;
	logic exec_en;
	logic wb_en;
	logic rd_wen;
	core_pkg::word_t pc;
	core_pkg::word_t rs1_val, rs2_val, rd_wdata;
	core_pkg::reg_addr_t rs1, rs2, rd_waddr;

	core_op_if op_if ();

	assign fetch_done = ivalid && iready;
	assign mem_done = dvalid && dready;
	assign iaddr = pc;

	soft_reset_timer soft_reset_timer_inst (.clock(clock), .reset(reset),
		.soft_reset_req(soft_reset_req), .int_reset(int_reset));

	core_sequencer core_sequencer_inst (.clock(clock), .reset(int_reset), .op(op_if.seq),
		.iready(iready), .dready(dready), .ivalid(ivalid), .dvalid(dvalid),
		.exec_en(exec_en), .wb_en(wb_en));

	core_decode core_decode_inst (.clock(clock), .reset(int_reset), .fetch_done(fetch_done),
		.idata(idata), .pc(pc), .rs1(rs1), .rs2(rs2), .rs1_val(rs1_val),
		.rs2_val(rs2_val), .op(op_if.decode));

	core_exec core_exec_inst (.clock(clock), .reset(int_reset), .exec_en(exec_en),
		.wb_en(wb_en), .mem_done(mem_done), .op(op_if.exec), .drdata(drdata),
		.pc(pc), .daddr(daddr), .dwdata(dwdata), .dwrite(dwrite), .dwstb(dwstb),
		.rd_waddr(rd_waddr), .rd_wdata(rd_wdata), .rd_wen(rd_wen),
		.soft_reset_req(soft_reset_req));

	core_regfile core_regfile_inst (.clock(clock), .reset(int_reset), .rd_wen(rd_wen),
		.rs1(rs1), .rs2(rs2), .rd_waddr(rd_waddr), .rd_wdata(rd_wdata),
		.rs1_val(rs1_val), .rs2_val(rs2_val));

endmodule

/* include/core_defs.svh */
/*
 * Build-time constants of the tiny RISC-V core.
 * Include wherever a width, the reset vector or the soft reset
 * settings are needed; the include directory must be on the search path.
 */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_XLEN 32                          // Data and address width
`define CORE_NREGS 32                         // Architectural registers
`define CORE_RESET_PC 32'h0                   // First fetch after any reset
`define CORE_SOFT_RESET_ADDR 32'hFFFF_FFF0    // Store here to restart the core
`define CORE_SOFT_RESET_CYCLES 31             // Length of the reset stretch

`endif

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it and check the log.

verilator --binary --timing --assert -f compile.f --top-module core_tb -o core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

/* verif/core_assertions.sv */
/*
 * Handshake and reset assertions for the core's memory ports.
 * Attached to every tiny_rv_core instance by the bind below.
 */
`timescale 1ns/1ps

module core_assertions (
	input logic clock,
	input logic reset,
	input core_pkg::word_t iaddr,
	input core_pkg::word_t daddr,
	input core_pkg::word_t dwdata,
	input logic ivalid,
	input logic iready,
	input logic dvalid,
	input logic dready,
	input logic dwrite
);

	fetch_stable: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else $error("iaddr changed while waiting for iready");

	data_stable: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata) && $stable(dwrite))
		else $error("data request changed while waiting for dready");

	one_port: assert property (@(posedge clock) disable iff (reset) !(ivalid && dvalid))
		else $error("ivalid and dvalid high together");

	quiet_in_reset: assert property (@(posedge clock)
		reset && $past(reset) |-> !ivalid && !dvalid)
		else $error("memory request during reset");

endmodule

bind tiny_rv_core core_assertions core_assertions_inst (.*);

/* verif/core_tb.sv */
/*
 * Testbench for the tiny RISC-V core. Assembles small programs, runs them
 * through a reference instruction set model for the expected fetch and
 * store traces, and checks the DUT against them with and without wait states.
 */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

	localparam logic [31:0] HALT = 32'h0000006F;    // jal x0, 0
	localparam logic [31:0] SEED = 32'h94445fda;

	logic clock, reset, iready, dready, ivalid, dvalid, dwrite;
	logic [3:0] dwstb;
	core_pkg::word_t iaddr, idata, daddr, dwdata, drdata;
	logic [31:0] imem [0:255];
	logic [31:0] imem2 [0:255];    // Program run after a soft reset
	logic [31:0] dmem [0:255];
	logic [31:0] ref_mem [0:255];
	logic [31:0] ref_regs [0:31];
	logic [31:0] exp_fetch [$];
	logic [31:0] exp_maddr [$];
	logic [31:0] exp_sdata [$];
	bit exp_mwrite [$];    // One entry per data transfer, set for stores
	logic [31:0] rand_state, wait_state;
	int errors, pc_emit, tick, soft_tick, wait_mode, ilow, dlow;
	bit to_second, soft_hit, soft_pending, mem_write;

	tiny_rv_core tiny_rv_core_inst (.clock(clock), .reset(reset), .iaddr(iaddr), .idata(idata),
		.ivalid(ivalid), .iready(iready), .dvalid(dvalid), .daddr(daddr), .dwdata(dwdata),
		.dwstb(dwstb), .dwrite(dwrite), .drdata(drdata), .dready(dready));

	assign idata = imem[iaddr[9:2]];
	assign drdata = dmem[daddr[9:2]];

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_rand();
		rand_state = lcg_next(rand_state);
		return rand_state;
	endfunction

	function automatic logic [31:0] enc_r(input logic [9:0] f, input logic [4:0] rs2, rs1, rd);
		return {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// Executes one instruction on the shadow state and returns the next pc
	function automatic logic [31:0] iss_step(input logic [31:0] pc, input logic [31:0] insn);
		logic [31:0] a, b, res, addr, next;
		logic [31:0] imm_i, imm_s, imm_b, imm_j;
		logic wr;
		a = ref_regs[insn[19:15]];
		b = ref_regs[insn[24:20]];
		imm_i = {{20{insn[31]}}, insn[31:20]};
		imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
		imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
		imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
		next = pc + 32'd4;
		res = 32'h0;
		wr = 1'b0;
		case (insn[6:0])
			7'b0110111: begin
				res = {insn[31:12], 12'h0};
				wr = 1'b1;
			end
			7'b0010011: if (insn[14:12] == 3'b000) begin
				res = a + imm_i;
				wr = 1'b1;
			end
			7'b0110011: begin
				wr = 1'b1;
				case ({insn[31:25], insn[14:12]})
					10'b0000000_000: res = a + b;
					10'b0100000_000: res = a - b;
					10'b0000000_111: res = a & b;
					10'b0000000_110: res = a | b;
					10'b0000000_100: res = a ^ b;
					10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: wr = 1'b0;
				endcase
			end
			7'b0000011: if (insn[14:12] == 3'b010) begin
				addr = a + imm_i;
				exp_maddr.push_back(addr);
				exp_mwrite.push_back(1'b0);
				res = ref_mem[addr[9:2]];
				wr = 1'b1;
			end
			7'b0100011: if (insn[14:12] == 3'b010) begin
				addr = a + imm_s;
				exp_maddr.push_back(addr);
				exp_mwrite.push_back(1'b1);
				exp_sdata.push_back(b);
				if (addr == `CORE_SOFT_RESET_ADDR) soft_hit = 1'b1;
				else ref_mem[addr[9:2]] = b;
			end
			7'b1100011: begin
				if ((insn[14:12] == 3'b000 && a == b) || (insn[14:12] == 3'b001 && a != b))
					next = pc + imm_b;
			end
			7'b1101111: begin
				res = pc + 32'd4;
				wr = 1'b1;
				next = pc + imm_j;
			end
			default: wr = 1'b0;    // Unsupported, acts as no-op
		endcase
		if (wr && insn[11:7] != 5'd0) ref_regs[insn[11:7]] = res;
		if (soft_hit) begin
			for (int i = 0; i < 32; i++) ref_regs[i] = 32'h0;
			next = `CORE_RESET_PC;
		end
		return next;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic emit(input logic [31:0] insn);
		if (to_second) imem2[pc_emit] = insn;
		else imem[pc_emit] = insn;
		pc_emit++;
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] upper;
		upper = v + 32'h800;    // Compensates the sign of the ADDI part
		emit({upper[31:12], rd, 7'b0110111});
		emit(enc_i(v[11:0], rd, 3'b000, rd, 7'b0010011));
	endtask

	task automatic start_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = HALT;
			imem2[i] = HALT;
		end
		pc_emit = 0;
		to_second = 1'b0;
	endtask

	task automatic build_alu();
		logic [9:0] ops [0:5];
		logic [31:0] lui_val;
		ops = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
			10'b0000000_110, 10'b0000000_100, 10'b0000000_010};
		start_program();
		load_reg(5'd1, next_rand());
		load_reg(5'd2, next_rand());
		load_reg(5'd3, next_rand() | 32'h8000_0000);    // Negative for SLT
		for (int i = 0; i < 6; i++) begin
			emit(enc_r(ops[i], 5'd2, 5'd1, 5'd4));
			emit(enc_s(12'(32'h100 + 4 * i), 5'd4, 5'd0));
		end
		emit(enc_r(10'b0000000_010, 5'd1, 5'd3, 5'd4));
		emit(enc_s(12'h120, 5'd4, 5'd0));
		emit(enc_r(10'b0000000_010, 5'd3, 5'd1, 5'd4));
		emit(enc_s(12'h124, 5'd4, 5'd0));
		emit(enc_i(12'hFFB, 5'd1, 3'b000, 5'd4, 7'b0010011));
		emit(enc_s(12'h128, 5'd4, 5'd0));
		lui_val = next_rand();
		emit({lui_val[19:0], 5'd4, 7'b0110111});
		emit(enc_s(12'h12C, 5'd4, 5'd0));
		emit(enc_s(12'h130, 5'd0, 5'd0));
	endtask

	task automatic build_load();
		start_program();
		dmem[8'hC0] = next_rand();
		dmem[8'hC1] = next_rand();
		emit(enc_i(12'h300, 5'd0, 3'b010, 5'd1, 7'b0000011));
		emit(enc_i(12'h304, 5'd0, 3'b010, 5'd2, 7'b0000011));
		emit(enc_r(10'b0000000_000, 5'd2, 5'd1, 5'd3));
		emit(enc_s(12'h308, 5'd3, 5'd0));
		emit(enc_s(12'h30C, 5'd1, 5'd0));
		emit(enc_s(12'h310, 5'd2, 5'd0));
	endtask

	task automatic build_branch();
		start_program();
		emit(enc_b(13'd8, 5'd0, 5'd0, 3'b000));    // Taken
		emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, 7'b0010011));
		emit(enc_b(13'd8, 5'd0, 5'd0, 3'b001));    // Not taken
		emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));
		emit(enc_b(13'd8, 5'd0, 5'd1, 3'b001));
		emit(enc_i(12'd2, 5'd0, 3'b000, 5'd5, 7'b0010011));
		emit(enc_j(21'd8, 5'd2));
		emit(enc_i(12'd3, 5'd0, 3'b000, 5'd5, 7'b0010011));
		emit(32'h0000000B);    // Custom opcode
		emit(enc_s(12'h380, 5'd2, 5'd0));
		emit(enc_s(12'h384, 5'd5, 5'd0));
		emit(enc_b(13'd8, 5'd0, 5'd1, 3'b000));
	endtask

	task automatic build_soft();
		start_program();
		load_reg(5'd1, next_rand());
		emit(enc_i(12'hFF0, 5'd0, 3'b000, 5'd2, 7'b0010011));
		emit(enc_s(12'h0, 5'd1, 5'd2));
		pc_emit = 0;
		to_second = 1'b1;
		for (int r = 1; r < 9; r++) emit(enc_s(12'(32'h200 + 4 * r), 5'(r), 5'd0));
	endtask

	task automatic run_ref();
		logic [31:0] pc, insn;
		bit second;
		pc = `CORE_RESET_PC;
		second = 1'b0;
		for (int n = 0; n < 300; n++) begin
			exp_fetch.push_back(pc);
			insn = second ? imem2[pc[9:2]] : imem[pc[9:2]];
			if (insn == HALT) break;
			pc = iss_step(pc, insn);
			if (soft_hit) begin
				soft_hit = 1'b0;
				second = 1'b1;
			end
		end
	endtask

	task automatic run_program(input int mode);
		int limit, cycles;
		bit swapped;
		@(posedge clock);
		#1 reset = 1'b1;
		wait_mode = mode;
		for (int i = 0; i < 32; i++) ref_regs[i] = 32'h0;
		for (int i = 0; i < 256; i++) ref_mem[i] = dmem[i];
		exp_fetch.delete();
		exp_maddr.delete();
		exp_sdata.delete();
		exp_mwrite.delete();
		soft_pending = 1'b0;
		run_ref();
		// Up to three wait states on each of two handshakes per instruction
		limit = 40 * exp_fetch.size() + 6 * exp_fetch.size() + 200 + `CORE_SOFT_RESET_CYCLES;
		repeat (5) @(posedge clock);
		#1 reset = 1'b0;
		cycles = 0;
		swapped = 1'b0;
		while (exp_fetch.size() > 0 || exp_mwrite.size() > 0) begin
			@(posedge clock);
			cycles++;
			if (soft_pending && !swapped) begin
				for (int i = 0; i < 256; i++) imem[i] = imem2[i];
				swapped = 1'b1;
			end
			if (cycles > limit) begin
				$display("Timeout: the program did not finish within %0d cycles", limit);
				$display("SOME TESTS FAILED");
				$finish;
			end
		end
	endtask

	// Ready lines with bounded random wait states
	always @(posedge clock) begin
		#1;
		wait_state = lcg_next(wait_state);
		iready = (wait_mode == 0) || wait_state[16] || (ilow >= 3);
		dready = (wait_mode == 0) || wait_state[24] || (dlow >= 3);
		ilow = iready ? 0 : ilow + 1;
		dlow = dready ? 0 : dlow + 1;
	end

	// Compares every fetch and data transfer with the reference trace
	always @(posedge clock) begin
		tick++;
		if (ivalid && iready) begin
			if (soft_pending && (tick - soft_tick <= `CORE_SOFT_RESET_CYCLES)) begin
				errors++;
				$display("A fetch came %0d cycles after the soft reset request", tick - soft_tick);
			end
			soft_pending = 1'b0;
			if (exp_fetch.size() > 0) check_value("iaddr", iaddr, exp_fetch.pop_front());
		end
		if (dvalid && dready) begin
			if (exp_mwrite.size() == 0) begin
				errors++;
				$display("The DUT made a data transfer at %h that the program does not make",
					daddr);
			end else begin
				mem_write = exp_mwrite.pop_front();
				check_value("dwrite", {31'h0, dwrite}, {31'h0, mem_write});
				check_value("dwstb", {28'h0, dwstb}, mem_write ? 32'hF : 32'h0);
				check_value("daddr", daddr, exp_maddr.pop_front());
				if (mem_write) check_value("dwdata", dwdata, exp_sdata.pop_front());
			end
			if (dwrite && daddr == `CORE_SOFT_RESET_ADDR) begin
				soft_pending = 1'b1;
				soft_tick = tick;
			end else if (dwrite) begin
				dmem[daddr[9:2]] = dwdata;
			end
		end
	end

	initial begin
		reset = 1'b1;
		iready = 1'b0;
		dready = 1'b0;
		wait_mode = 0;
		errors = 0;
		tick = 0;
		soft_tick = 0;
		ilow = 0;
		dlow = 0;
		soft_hit = 1'b0;
		soft_pending = 1'b0;
		mem_write = 1'b0;
		wait_state = SEED;
		for (int i = 0; i < 256; i++) dmem[i] = 32'(i) * 32'h9E3779B1 ^ 32'h5A5A_0F0F;
		start_program();
		for (int mode = 0; mode < 2; mode++) begin
			rand_state = SEED;    // Same programs with and without wait states
			build_alu();
			run_program(mode);
			build_load();
			run_program(mode);
			build_branch();
			run_program(mode);
		end
		build_soft();
		run_program(0);
		$display("Errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
